// ==== hdl/intra_pkg.sv ====
package intra_pkg;

    // ----------------------------------------------------------
    // Data widths
    // ----------------------------------------------------------

    // Luma sample width
    localparam int PIX_W = 8;

    // Macroblock coordinate width, up to 1024 macroblocks per axis
    localparam int COORD_W = 10;

    // ----------------------------------------------------------
    // Prediction modes
    // ----------------------------------------------------------

    typedef enum logic [1:0] {
        MODE_DC = 2'd0,
        MODE_V  = 2'd1,
        MODE_H  = 2'd2,
        MODE_TM = 2'd3
    } pred_mode_e;

    // ----------------------------------------------------------
    // State encodings
    // ----------------------------------------------------------

    // DC accumulator, binary coded
    typedef enum logic [2:0] {
        DC_IDLE  = 3'd0,
        DC_BOTH  = 3'd1,
        DC_TOP   = 3'd2,
        DC_LEFT  = 3'd3,
        DC_NONE  = 3'd4,
        DC_ROUND = 3'd5
    } dc_state_e;

    // Top-level sequencer
    typedef enum logic [2:0] {
        CT_IDLE    = 3'd0,
        CT_SUM     = 3'd1,
        CT_ROWS    = 3'd2,
        CT_ACK     = 3'd3,
        CT_RELEASE = 3'd4
    } ctrl_state_e;

endpackage

// ==== hdl/pred_if.sv ====
// ----------------------------------------------------------
// Controller to DC sum unit
// ----------------------------------------------------------
interface dc_sum_if #(
    parameter int BLOCK_SIZE = 16
);
    import intra_pkg::*;

    logic                          start;
    logic [COORD_W-1:0]            mb_x;
    logic [COORD_W-1:0]            mb_y;
    logic [BLOCK_SIZE*PIX_W-1:0]   top;
    logic [BLOCK_SIZE*PIX_W-1:0]   left;
    // Valid only while done is high
    logic [PIX_W-1:0]              dc;
    logic                          done;

    modport ctrl (
        output start, mb_x, mb_y, top, left,
        input  dc, done
    );

    modport unit (
        input  start, mb_x, mb_y, top, left,
        output dc, done
    );

endinterface

// ----------------------------------------------------------
// Controller to row generator
// ----------------------------------------------------------
interface row_gen_if #(
    parameter int BLOCK_SIZE = 16
);
    import intra_pkg::*;

    localparam int IDX_W = $clog2(BLOCK_SIZE);

    logic                          start;
    pred_mode_e                    mode;
    logic [PIX_W-1:0]              dc;
    logic [BLOCK_SIZE*PIX_W-1:0]   top;
    logic [BLOCK_SIZE*PIX_W-1:0]   left;
    logic [PIX_W-1:0]              top_left;

    // Row stream back to the top level
    logic                          row_valid;
    logic [IDX_W-1:0]              row_idx;
    logic [BLOCK_SIZE*PIX_W-1:0]   row;
    logic                          done;

    modport ctrl (
        output start, mode, dc, top, left, top_left,
        input  row_valid, row_idx, row, done
    );

    modport unit (
        input  start, mode, dc, top, left, top_left,
        output row_valid, row_idx, row, done
    );

endinterface

// ==== hdl/dc_sum_unit.sv ====
module dc_sum_unit #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    dc_sum_if.unit  sum
);
    import intra_pkg::*;

    // Divisor is 2*BLOCK_SIZE in every mode since a single edge is doubled
    localparam int SHIFT = $clog2(2 * BLOCK_SIZE);
    localparam int ACC_W = PIX_W + SHIFT;
    localparam int IDX_W = $clog2(BLOCK_SIZE);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BLOCK_SIZE - 1);
    // Mid-grey preloaded so that the rounding step yields 128
    localparam logic [ACC_W-1:0] NONE_ACC = ACC_W'(1 << (PIX_W - 1)) << SHIFT;

    dc_state_e          state_q;
    dc_state_e          state_d;
    logic [IDX_W-1:0]   idx_q;
    logic [ACC_W-1:0]   acc_q;
    logic [ACC_W-1:0]   rounded;
    logic [PIX_W-1:0]   top_px;
    logic [PIX_W-1:0]   left_px;
    logic               top_avail;
    logic               left_avail;

    // Top row exists below the first macroblock row, left column right of the first column
    assign top_avail  = (sum.mb_y != '0);
    assign left_avail = (sum.mb_x != '0);

    assign top_px  = sum.top[idx_q*PIX_W +: PIX_W];
    assign left_px = sum.left[idx_q*PIX_W +: PIX_W];

    // ----------------------------------------------------------
    // State sequencing
    // ----------------------------------------------------------
    always_comb begin
        state_d = state_q;
        case (state_q)
            DC_IDLE: begin
                if (sum.start) begin
                    if (top_avail && left_avail)
                        state_d = DC_BOTH;
                    else if (top_avail)
                        state_d = DC_TOP;
                    else if (left_avail)
                        state_d = DC_LEFT;
                    else
                        state_d = DC_NONE;
                end
            end
            DC_BOTH, DC_TOP, DC_LEFT: begin
                if (idx_q == LAST_IDX)
                    state_d = DC_ROUND;
            end
            DC_NONE:  state_d = DC_ROUND;
            DC_ROUND: state_d = DC_IDLE;
            default:  state_d = DC_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= DC_IDLE;
            idx_q   <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == DC_IDLE)
                idx_q <= '0;
            else if (state_q inside {DC_BOTH, DC_TOP, DC_LEFT})
                idx_q <= idx_q + 1'b1;
        end
    end

    // ----------------------------------------------------------
    // Accumulator, one pixel pair per cycle
    // ----------------------------------------------------------
    always_ff @(posedge clk) begin
        case (state_q)
            DC_IDLE: acc_q <= '0;
            DC_BOTH: acc_q <= acc_q + ACC_W'(top_px) + ACC_W'(left_px);
            DC_TOP:  acc_q <= acc_q + (ACC_W'(top_px) << 1);
            DC_LEFT: acc_q <= acc_q + (ACC_W'(left_px) << 1);
            DC_NONE: acc_q <= NONE_ACC;
            default: acc_q <= acc_q;
        endcase
    end

    // Add half the divisor, then divide
    assign rounded  = acc_q + ACC_W'(BLOCK_SIZE);
    assign sum.dc   = rounded[SHIFT +: PIX_W];
    assign sum.done = (state_q == DC_ROUND);

endmodule

// ==== hdl/pred_row_gen.sv ====
module pred_row_gen #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic    clk,
    input  logic    rst_n,
    row_gen_if.unit rg
);
    import intra_pkg::*;

    localparam int IDX_W = $clog2(BLOCK_SIZE);
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(BLOCK_SIZE - 1);

    logic                         busy_q;
    logic [IDX_W-1:0]             cnt_q;
    logic                         load;
    logic [IDX_W-1:0]             sel_idx;
    logic                         row_valid_q;
    logic [IDX_W-1:0]             row_idx_q;
    logic [BLOCK_SIZE*PIX_W-1:0]  row_q;
    logic                         done_q;

    logic [BLOCK_SIZE*PIX_W-1:0]  row_next;
    logic [PIX_W-1:0]             left_px;
    logic [PIX_W-1:0]             top_px;
    // Range -255..510 needs two extra bits
    logic signed [PIX_W+1:0]      tm_sum;

    // Row 0 is formed in the start cycle itself, later rows from the counter
    assign load    = rg.start || busy_q;
    assign sel_idx = busy_q ? cnt_q : '0;
    assign left_px = rg.left[sel_idx*PIX_W +: PIX_W];

    // ----------------------------------------------------------
    // Row formation per mode
    // ----------------------------------------------------------
    always_comb begin
        row_next = '0;
        top_px   = '0;
        tm_sum   = '0;
        for (int c = 0; c < BLOCK_SIZE; c++) begin
            top_px = rg.top[c*PIX_W +: PIX_W];
            tm_sum = $signed({2'b00, left_px}) + $signed({2'b00, top_px})
                     - $signed({2'b00, rg.top_left});
            case (rg.mode)
                MODE_DC: row_next[c*PIX_W +: PIX_W] = rg.dc;
                MODE_V:  row_next[c*PIX_W +: PIX_W] = top_px;
                MODE_H:  row_next[c*PIX_W +: PIX_W] = left_px;
                default: begin
                    // TM clip, sign bit first, then overflow bit
                    if (tm_sum[PIX_W+1])
                        row_next[c*PIX_W +: PIX_W] = '0;
                    else if (tm_sum[PIX_W])
                        row_next[c*PIX_W +: PIX_W] = '1;
                    else
                        row_next[c*PIX_W +: PIX_W] = tm_sum[PIX_W-1:0];
                end
            endcase
        end
    end

    // ----------------------------------------------------------
    // Row counter and stream control
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_q      <= 1'b0;
            cnt_q       <= '0;
            row_valid_q <= 1'b0;
            row_idx_q   <= '0;
            done_q      <= 1'b0;
        end else begin
            row_valid_q <= load;
            if (load)
                row_idx_q <= sel_idx;
            if (rg.start) begin
                busy_q <= 1'b1;
                cnt_q  <= IDX_W'(1);
            end else if (busy_q) begin
                cnt_q <= cnt_q + 1'b1;
                if (cnt_q == LAST_IDX)
                    busy_q <= 1'b0;
            end
            // Pulse in the cycle after the last row
            done_q <= row_valid_q && (row_idx_q == LAST_IDX);
        end
    end

    always_ff @(posedge clk) begin
        if (load)
            row_q <= row_next;
    end

    assign rg.row_valid = row_valid_q;
    assign rg.row_idx   = row_idx_q;
    assign rg.row       = row_q;
    assign rg.done      = done_q;

endmodule

// ==== hdl/pred_ctrl.sv ====
module pred_ctrl #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  req_i,
    input  intra_pkg::pred_mode_e                 mode_i,
    input  logic [intra_pkg::COORD_W-1:0]         mb_x_i,
    input  logic [intra_pkg::COORD_W-1:0]         mb_y_i,
    input  logic [BLOCK_SIZE*intra_pkg::PIX_W-1:0] top_i,
    input  logic [BLOCK_SIZE*intra_pkg::PIX_W-1:0] left_i,
    input  logic [intra_pkg::PIX_W-1:0]           top_left_i,
    output logic                                  ack_o,
    dc_sum_if.ctrl                                sum,
    row_gen_if.ctrl                               rg
);
    import intra_pkg::*;

    ctrl_state_e                  state_q;
    logic                         sum_start_q;
    logic                         rg_start_q;

    // Operands captured at request time
    pred_mode_e                   mode_q;
    logic [COORD_W-1:0]           mb_x_q;
    logic [COORD_W-1:0]           mb_y_q;
    logic [BLOCK_SIZE*PIX_W-1:0]  top_q;
    logic [BLOCK_SIZE*PIX_W-1:0]  left_q;
    logic [PIX_W-1:0]             top_left_q;
    logic [PIX_W-1:0]             dc_q;

    // ----------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q     <= CT_IDLE;
            sum_start_q <= 1'b0;
            rg_start_q  <= 1'b0;
        end else begin
            sum_start_q <= 1'b0;
            rg_start_q  <= 1'b0;
            case (state_q)
                CT_IDLE: begin
                    if (req_i) begin
                        // DC needs the edge mean before any row can go out
                        if (mode_i == MODE_DC) begin
                            sum_start_q <= 1'b1;
                            state_q     <= CT_SUM;
                        end else begin
                            rg_start_q <= 1'b1;
                            state_q    <= CT_ROWS;
                        end
                    end
                end
                CT_SUM: begin
                    if (sum.done) begin
                        rg_start_q <= 1'b1;
                        state_q    <= CT_ROWS;
                    end
                end
                CT_ROWS: begin
                    if (rg.done)
                        state_q <= CT_ACK;
                end
                CT_ACK: begin
                    if (!req_i)
                        state_q <= CT_RELEASE;
                end
                default: state_q <= CT_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == CT_IDLE && req_i) begin
            mode_q     <= mode_i;
            mb_x_q     <= mb_x_i;
            mb_y_q     <= mb_y_i;
            top_q      <= top_i;
            left_q     <= left_i;
            top_left_q <= top_left_i;
        end
        if (state_q == CT_SUM && sum.done)
            dc_q <= sum.dc;
    end

    // Ack stays up through the release cycle
    assign ack_o = (state_q == CT_ACK) || (state_q == CT_RELEASE);

    assign sum.start = sum_start_q;
    assign sum.mb_x  = mb_x_q;
    assign sum.mb_y  = mb_y_q;
    assign sum.top   = top_q;
    assign sum.left  = left_q;

    assign rg.start    = rg_start_q;
    assign rg.mode     = mode_q;
    assign rg.dc       = dc_q;
    assign rg.top      = top_q;
    assign rg.left     = left_q;
    assign rg.top_left = top_left_q;

endmodule

// ==== hdl/intra_pred_y16.sv ====
module intra_pred_y16 #(
    parameter int BLOCK_SIZE = 16
) (
    input  logic                                   clk,
    input  logic                                   rst_n,
    // Four-phase request
    input  logic                                   req_i,
    input  intra_pkg::pred_mode_e                  mode_i,
    input  logic [intra_pkg::COORD_W-1:0]          mb_x_i,
    input  logic [intra_pkg::COORD_W-1:0]          mb_y_i,
    input  logic [BLOCK_SIZE*intra_pkg::PIX_W-1:0] top_i,
    input  logic [BLOCK_SIZE*intra_pkg::PIX_W-1:0] left_i,
    input  logic [intra_pkg::PIX_W-1:0]            top_left_i,
    output logic                                   ack_o,
    // Predicted rows, no back-pressure
    output logic                                   row_valid_o,
    output logic [$clog2(BLOCK_SIZE)-1:0]          row_idx_o,
    output logic [BLOCK_SIZE*intra_pkg::PIX_W-1:0] row_o
);
    import intra_pkg::*;

    dc_sum_if  #(.BLOCK_SIZE(BLOCK_SIZE)) sum_bus ();
    row_gen_if #(.BLOCK_SIZE(BLOCK_SIZE)) rg_bus ();

    // ----------------------------------------------------------
    // Controller
    // ----------------------------------------------------------
    pred_ctrl #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_i      (req_i),
        .mode_i     (mode_i),
        .mb_x_i     (mb_x_i),
        .mb_y_i     (mb_y_i),
        .top_i      (top_i),
        .left_i     (left_i),
        .top_left_i (top_left_i),
        .ack_o      (ack_o),
        .sum        (sum_bus.ctrl),
        .rg         (rg_bus.ctrl)
    );

    // ----------------------------------------------------------
    // Datapath units
    // ----------------------------------------------------------
    dc_sum_unit #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_dc_sum (
        .clk   (clk),
        .rst_n (rst_n),
        .sum   (sum_bus.unit)
    );

    pred_row_gen #(
        .BLOCK_SIZE (BLOCK_SIZE)
    ) u_row_gen (
        .clk   (clk),
        .rst_n (rst_n),
        .rg    (rg_bus.unit)
    );

    // Row stream leaves straight from the generator registers
    assign row_valid_o = rg_bus.row_valid;
    assign row_idx_o   = rg_bus.row_idx;
    assign row_o       = rg_bus.row;

endmodule

// ==== tb/intra_pred_assertions.sv ====
module intra_pred_assertions #(
    parameter int IDX_W = 4
) (
    input logic             clk,
    input logic             rst_n,
    input logic             req_i,
    input logic             ack_i,
    input logic             row_valid_i,
    input logic [IDX_W-1:0] row_idx_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------------------------
    // Four-phase handshake
    // ----------------------------------------------------------
    ack_rise_with_req: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(ack_i) |-> req_i)
        else $error("ack rose while req was low");

    ack_fall_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        $fell(ack_i) |-> !$past(req_i))
        else $error("ack fell before req was released");

    // ----------------------------------------------------------
    // Row stream
    // ----------------------------------------------------------
    no_rows_during_ack: assert property (@(posedge clk) disable iff (!rst_n)
        !(row_valid_i && ack_i))
        else $error("row valid while ack high");

    idx_in_order: assert property (@(posedge clk) disable iff (!rst_n)
        (row_valid_i && $past(row_valid_i)) |-> (row_idx_i == $past(row_idx_i) + 1'b1))
        else $error("row indices not consecutive");

endmodule

bind intra_pred_y16 intra_pred_assertions #(.IDX_W($clog2(BLOCK_SIZE))) u_assertions (
    .clk         (clk),
    .rst_n       (rst_n),
    .req_i       (req_i),
    .ack_i       (ack_o),
    .row_valid_i (row_valid_o),
    .row_idx_i   (row_idx_o)
);

// ==== tb/tb_intra_pred.sv ====
module tb_intra_pred;
    timeunit 1ns;
    timeprecision 100ps;
    import intra_pkg::*;

    localparam int BS    = 16;
    localparam int ROW_W = BS * PIX_W;
    localparam int LIMIT = 2000;

    logic               clk;
    logic               rst_n;
    logic               req_i;
    pred_mode_e         mode_i;
    logic [COORD_W-1:0] mb_x_i;
    logic [COORD_W-1:0] mb_y_i;
    logic [ROW_W-1:0]   top_i;
    logic [ROW_W-1:0]   left_i;
    logic [PIX_W-1:0]   top_left_i;
    logic               ack_o;
    logic               row_valid_o;
    logic [3:0]         row_idx_o;
    logic [ROW_W-1:0]   row_o;

    logic [ROW_W-1:0]   got_rows[BS];
    logic [3:0]         got_idx[BS];
    int                 got_cnt;
    int                 mism_cnt;
    int                 other_cnt;

    intra_pred_y16 #(.BLOCK_SIZE(BS)) dut0 (
        .clk(clk), .rst_n(rst_n), .req_i(req_i), .mode_i(mode_i),
        .mb_x_i(mb_x_i), .mb_y_i(mb_y_i), .top_i(top_i), .left_i(left_i),
        .top_left_i(top_left_i), .ack_o(ack_o), .row_valid_o(row_valid_o),
        .row_idx_o(row_idx_o), .row_o(row_o)
    );

    always #5 clk = ~clk;

    // Row collector sampling values settled since the previous edge
    always @(posedge clk) begin
        if (row_valid_o) begin
            if (got_cnt < BS) begin
                got_rows[got_cnt] = row_o;
                got_idx[got_cnt]  = row_idx_o;
            end
            got_cnt = got_cnt + 1;
        end
    end

    // ----------------------------------------------------------
    // Reference model from the mode rules
    // ----------------------------------------------------------
    function automatic logic [PIX_W-1:0] mean_of_edges(input logic [COORD_W-1:0] mbx,
            input logic [COORD_W-1:0] mby, input logic [ROW_W-1:0] t,
            input logic [ROW_W-1:0] l);
        int st;
        int sl;
        st = 0;
        sl = 0;
        for (int i = 0; i < BS; i++) begin
            st += int'(t[i*PIX_W +: PIX_W]);
            sl += int'(l[i*PIX_W +: PIX_W]);
        end
        if (mbx != 0 && mby != 0)
            return PIX_W'((st + sl + 16) >> 5);
        else if (mby != 0)
            return PIX_W'((2 * st + 16) >> 5);
        else if (mbx != 0)
            return PIX_W'((2 * sl + 16) >> 5);
        return 8'd128;
    endfunction

    function automatic logic [ROW_W-1:0] expected_row(input pred_mode_e m,
            input logic [PIX_W-1:0] dcv, input logic [ROW_W-1:0] t,
            input logic [ROW_W-1:0] l, input logic [PIX_W-1:0] tl, input int r);
        logic [ROW_W-1:0] res;
        int v;
        res = '0;
        for (int c = 0; c < BS; c++) begin
            v = int'(l[r*PIX_W +: PIX_W]) + int'(t[c*PIX_W +: PIX_W]) - int'(tl);
            if (v < 0)
                v = 0;
            if (v > 255)
                v = 255;
            case (m)
                MODE_DC: res[c*PIX_W +: PIX_W] = dcv;
                MODE_V:  res[c*PIX_W +: PIX_W] = t[c*PIX_W +: PIX_W];
                MODE_H:  res[c*PIX_W +: PIX_W] = l[r*PIX_W +: PIX_W];
                default: res[c*PIX_W +: PIX_W] = PIX_W'(v);
            endcase
        end
        return res;
    endfunction

    task automatic wait_ack(input logic level, input string name);
        int n;
        n = 0;
        while (ack_o !== level && n < LIMIT) begin
            @(posedge clk);
            #1;
            n++;
        end
        assert (ack_o === level) else begin
            other_cnt++;
            $display("Test %s: ack did not reach %0b within %0d cycles", name, level, LIMIT);
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------
    initial begin
        int fd;
        int m;
        int gap;
        string line;
        string name;
        logic [ROW_W-1:0] f_row0;
        logic [ROW_W-1:0] f_row15;
        logic [ROW_W-1:0] exp_row;
        logic [PIX_W-1:0] dcv;
        clk = 0;
        rst_n = 0;
        req_i = 0;
        mode_i = MODE_DC;
        mb_x_i = '0;
        mb_y_i = '0;
        top_i = '0;
        left_i = '0;
        top_left_i = '0;
        got_cnt = 0;
        mism_cnt = 0;
        other_cnt = 0;
        void'($urandom(32'h7c26_3362));
        repeat (8) @(posedge clk);
        #1 rst_n = 1;
        fd = $fopen("tb/pred_input.txt", "r");
        if (fd == 0) begin
            other_cnt++;
            $display("Could not open the stimulus file tb/pred_input.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 2 || line[0] == "#")
                continue;
            void'($sscanf(line, "%s %d %d %d %h %h %h %h %h", name, m, mb_x_i, mb_y_i,
                          top_left_i, top_i, left_i, f_row0, f_row15));
            mode_i = pred_mode_e'(m[1:0]);
            gap = $urandom % 6;
            repeat (gap) @(posedge clk);
            @(posedge clk);
            #1;
            got_cnt = 0;
            req_i = 1;
            wait_ack(1'b1, name);
            // Requester lingers a few cycles before releasing
            repeat (3) begin
                @(posedge clk);
                #1;
                assert (ack_o === 1'b1) else begin
                    other_cnt++;
                    $display("Test %s: ack dropped while req was still high", name);
                end
            end
            req_i = 0;
            wait_ack(1'b0, name);
            assert (got_cnt == BS) else begin
                mism_cnt++;
                $display("Mismatch %s row count: expected %0d, actual %0d", name, BS, got_cnt);
            end
            dcv = mean_of_edges(mb_x_i, mb_y_i, top_i, left_i);
            for (int r = 0; r < BS && r < got_cnt; r++) begin
                exp_row = expected_row(mode_i, dcv, top_i, left_i, top_left_i, r);
                assert (got_idx[r] == 4'(r)) else begin
                    mism_cnt++;
                    $display("Mismatch %s row index: expected %0d, actual %0d",
                             name, r, got_idx[r]);
                end
                assert (got_rows[r] == exp_row) else begin
                    mism_cnt++;
                    $display("Mismatch %s row %0d: expected %h, actual %h",
                             name, r, exp_row, got_rows[r]);
                end
            end
            // File values are checked against the model as well
            exp_row = expected_row(mode_i, dcv, top_i, left_i, top_left_i, 0);
            assert (f_row0 == exp_row) else begin
                mism_cnt++;
                $display("Mismatch %s file row 0: expected %h, actual %h", name, exp_row, f_row0);
            end
            exp_row = expected_row(mode_i, dcv, top_i, left_i, top_left_i, BS - 1);
            assert (f_row15 == exp_row) else begin
                mism_cnt++;
                $display("Mismatch %s file row 15: expected %h, actual %h",
                         name, exp_row, f_row15);
            end
        end
        if (fd != 0)
            $fclose(fd);
        $display("Errors: %0d mismatches, %0d other failures", mism_cnt, other_cnt);
        if (mism_cnt == 0 && other_cnt == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

// ==== tb/pred_input.txt ====
# name mode(0=DC 1=V 2=H 3=TM) mb_x mb_y top_left(hex) top(hex) left(hex) row0(hex) row15(hex)
# Edge and row vectors are written with pixel 15 first
dc_both_flat 0 1 1 00 50505050505050505050505050505050 30303030303030303030303030303030 40404040404040404040404040404040 40404040404040404040404040404040
dc_both_ramp 0 4 7 00 0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 10101010101010101010101010101010 10101010101010101010101010101010
dc_left_only 0 3 0 00 ffffffffffffffffffffffffffffffff 21212121212121212121212121212121 21212121212121212121212121212121 21212121212121212121212121212121
dc_top_only 0 0 2 00 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 00000000000000000000000000000000 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f 7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f7f
dc_none 0 0 0 00 ffffffffffffffffffffffffffffffff 00000000000000000000000000000000 80808080808080808080808080808080 80808080808080808080808080808080
v_ramp 1 5 5 00 0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 0f0e0d0c0b0a09080706050403020100 0f0e0d0c0b0a09080706050403020100
h_ramp 2 5 5 00 0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 10101010101010101010101010101010 1f1f1f1f1f1f1f1f1f1f1f1f1f1f1f1f
tm_sat 3 2 2 80 ff00ff00ff00ff00ff00ff00ff00ff00 f0e0d0c0b0a090807060504030201000 7f007f007f007f007f007f007f007f00 ff70ff70ff70ff70ff70ff70ff70ff70
tm_flat 3 9 9 40 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040 40404040404040404040404040404040
dc_both_max 0 1023 1023 00 0f0e0d0c0b0a09080706050403020100 1f1e1d1c1b1a19181716151413121110 10101010101010101010101010101010 10101010101010101010101010101010
v_flat 1 0 0 00 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa 00000000000000000000000000000000 aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa aaaaaaaaaaaaaaaaaaaaaaaaaaaaaaaa
dc_none_again 0 0 0 00 00000000000000000000000000000000 ffffffffffffffffffffffffffffffff 80808080808080808080808080808080 80808080808080808080808080808080

// ==== src.f ====
hdl/intra_pkg.sv
hdl/pred_if.sv
hdl/dc_sum_unit.sv
hdl/pred_row_gen.sv
hdl/pred_ctrl.sv
hdl/intra_pred_y16.sv
tb/intra_pred_assertions.sv
tb/tb_intra_pred.sv

// ==== run_sim.sh ====
#!/bin/bash
# Build with Verilator, run, and look for the pass message in the log
cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -f src.f --top-module tb_intra_pred \
    --Mdir obj_dir -o tb_sim \
    && ./obj_dir/tb_sim > sim.log 2>&1

cat sim.log 2>/dev/null

grep -q "Everything OK" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
